/* sacc.f */
verilog/sacc_pkg.sv
verilog/sacc_tag_fifo.sv
verilog/sacc_scheduler.sv
verilog/sacc_shift_add_pipe.sv
verilog/sacc_ctrl.sv
verilog/sacc_top.sv
sim/tb_sacc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sacc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sacc -f sacc.f

sim_out=$(./obj_dir/Vtb_sacc)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

/* sim/tb_sacc.sv */
// Scaled accumulator testbench
`timescale 1ns/1ps

module tb_sacc;
    import sacc_pkg::*;

    localparam int CLK_HALF  = 4;
    localparam int RST_CYCLES = 16;
    localparam int SEED      = 32'hcabe;

    // Items and blocks over all tests
    localparam int N_ITEMS        = 12 + 3 * 20 + 30 + 11 + 26;
    localparam int N_BLOCKS       = 8;
    localparam int STIM_CYCLES    = RST_CYCLES + N_ITEMS * 3 + N_BLOCKS * 24;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES * 20 + 1000;

    logic   clk;
    logic   rst_n;
    logic   clear;
    logic   add_valid;
    acc_t   add_data;
    logic   scale_valid;
    shift_t scale_shift;
    logic   reduce;
    logic   ready;
    logic   valid;
    acc_t   acc;

    // Current block, one entry per input in order
    bit     blk_flags[$];
    acc_t   blk_vals[$];

    acc_t   expected_acc;
    logic   check_armed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     add_stalls;
    int     scale_stalls;

    sacc_top u_dut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .clear_i       (clear),
        .add_valid_i   (add_valid),
        .add_i         (add_data),
        .scale_valid_i (scale_valid),
        .scale_i       (scale_shift),
        .reduce_i      (reduce),
        .ready_o       (ready),
        .valid_o       (valid),
        .acc_o         (acc)
    );

    always #CLK_HALF clk = ~clk;

    // Each addend is shifted by every shift that comes after it
    function automatic acc_t expected_sum(input bit flags[$], input acc_t vals[$]);
        int unsigned total;
        logic [63:0] sum;
        total = 0;
        sum   = '0;
        for (int i = flags.size() - 1; i >= 0; i--) begin
            if (flags[i]) begin
                total += vals[i];
            end else begin
                sum = sum + 64'(vals[i] >> total);
            end
        end
        return acc_t'(sum);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        idle_cycles(1);
        clear = 1'b0;
    endtask

    task automatic pulse_reduce();
        reduce = 1'b1;
        idle_cycles(1);
        reduce = 1'b0;
    endtask

    task automatic add_item(input bit is_scale, input acc_t value);
        blk_flags.push_back(is_scale);
        blk_vals.push_back(value);
    endtask

    // Multiples of 2**total keep every shift exact
    task automatic fill_addends();
        int unsigned total;
        total = 0;
        foreach (blk_flags[i]) begin
            if (blk_flags[i]) begin
                total += blk_vals[i];
            end
        end
        foreach (blk_flags[i]) begin
            if (!blk_flags[i]) begin
                blk_vals[i] = acc_t'($urandom_range(1, 4095)) << total;
            end
        end
    endtask

    task automatic make_random_block(input int n_items, input int max_scales);
        int scales;
        scales = 0;
        blk_flags.delete();
        blk_vals.delete();
        for (int i = 0; i < n_items; i++) begin
            if (scales < max_scales && $urandom_range(0, 4) == 0) begin
                add_item(1'b1, acc_t'($urandom_range(1, 2)));
                scales++;
            end else begin
                add_item(1'b0, '0);
            end
        end
        fill_addends();
    endtask

    // Hold strobe and data until ready_o is seen high
    task automatic drive_item(input bit is_scale, input acc_t value);
        if (is_scale) begin
            scale_valid = 1'b1;
            scale_shift = shift_t'(value);
        end else begin
            add_valid = 1'b1;
            add_data  = value;
        end
        @(negedge clk);
        while (!ready) begin
            if (is_scale) begin
                scale_stalls++;
            end else begin
                add_stalls++;
            end
            @(negedge clk);
        end
        idle_cycles(1);
        scale_valid = 1'b0;
        add_valid   = 1'b0;
    endtask

    task automatic play_block(input int max_gap);
        add_stalls   = 0;
        scale_stalls = 0;
        foreach (blk_flags[i]) begin
            drive_item(blk_flags[i], blk_vals[i]);
            if (max_gap > 0) begin
                idle_cycles($urandom_range(0, max_gap));
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic check_block(input string name, input int err_before);
        acc_t held;
        idle_cycles(4);
        pulse_reduce();
        expected_acc = expected_sum(blk_flags, blk_vals);
        check_armed  = 1'b1;
        wait (check_armed == 1'b0);
        held = acc;
        repeat (4) begin
            @(negedge clk);
            if (!valid || acc !== held) begin
                $display("valid_o or acc_o changed before clear_i");
                errors++;
            end
        end
        idle_cycles(1);
        pulse_clear();
        @(negedge clk);
        if (valid !== 1'b0) begin
            $display("Mismatch valid_o: got 0x%0h, expected 0x0 after clear_i", valid);
            errors++;
        end
        if (acc !== '0) begin
            $display("Mismatch acc_o: got 0x%08h, expected 0x00000000 after clear_i", acc);
            errors++;
        end
        idle_cycles(1);
        report_test(name, err_before);
    endtask

    initial begin : compare_results
        forever begin
            @(negedge clk);
            if (check_armed && valid) begin
                if (acc !== expected_acc) begin
                    $display("Mismatch acc_o: got 0x%08h, expected 0x%08h", acc, expected_acc);
                    errors++;
                end
                check_armed = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * 2 * CLK_HALF);
        $display("Timeout after %0d cycles, valid_o never came", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int err_before;
        clk          = 1'b0;
        rst_n        = 1'b0;
        clear        = 1'b0;
        add_valid    = 1'b0;
        add_data     = '0;
        scale_valid  = 1'b0;
        scale_shift  = '0;
        reduce       = 1'b0;
        check_armed  = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        idle_cycles(RST_CYCLES);
        rst_n = 1'b1;
        idle_cycles(2);

        err_before = errors;
        @(negedge clk);
        if (ready !== 1'b1) begin
            $display("Mismatch ready_o: got 0x%0h, expected 0x1", ready);
            errors++;
        end
        if (valid !== 1'b0) begin
            $display("Mismatch valid_o: got 0x%0h, expected 0x0", valid);
            errors++;
        end
        if (acc !== '0) begin
            $display("Mismatch acc_o: got 0x%08h, expected 0x00000000", acc);
            errors++;
        end
        idle_cycles(1);
        report_test("reset values", err_before);

        err_before = errors;
        make_random_block(12, 0);
        play_block(2);
        check_block("plain sum", err_before);

        for (int b = 0; b < 3; b++) begin
            err_before = errors;
            make_random_block(20, 4);
            play_block(2);
            check_block($sformatf("mixed block %0d", b), err_before);
        end

        // Scale right behind an addend stalls the source
        err_before = errors;
        blk_flags.delete();
        blk_vals.delete();
        for (int i = 0; i < 30; i++) begin
            add_item(i % 6 == 5, acc_t'($urandom_range(1, 2)));
        end
        fill_addends();
        play_block(0);
        if (add_stalls + scale_stalls == 0) begin
            $display("ready_o never fell during the burst");
            errors++;
        end
        check_block("burst", err_before);

        err_before = errors;
        blk_flags.delete();
        blk_vals.delete();
        repeat (4) add_item(1'b0, '0);
        add_item(1'b1, acc_t'(2));
        repeat (3) add_item(1'b0, '0);
        add_item(1'b1, acc_t'(1));
        repeat (2) add_item(1'b0, '0);
        fill_addends();
        play_block(0);
        if (scale_stalls == 0) begin
            $display("Scale event was taken while addends were still queued");
            errors++;
        end
        check_block("scale behind queued addends", err_before);

        // Abandoned block, then a fresh one
        err_before = errors;
        make_random_block(10, 2);
        play_block(1);
        pulse_clear();
        idle_cycles(2);
        make_random_block(16, 3);
        play_block(1);
        check_block("clear mid block", err_before);

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/sacc_top.sv */
// Scaled streaming accumulator top
`timescale 1ns/1ps

module sacc_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              clear_i,
    input  logic              add_valid_i,
    input  sacc_pkg::acc_t    add_i,
    input  logic              scale_valid_i,
    input  sacc_pkg::shift_t  scale_i,
    input  logic              reduce_i,
    output logic              ready_o,
    output logic              valid_o,
    output sacc_pkg::acc_t    acc_o
);
    import sacc_pkg::*;

    logic   addend_push;
    logic   addend_pop;
    acc_t   addend_wdata;
    tag_t   addend_wtag;
    acc_t   addend_data;
    tag_t   addend_tag;
    logic   addend_full;
    logic   addend_empty;

    logic   factor_push;
    logic   factor_pop;
    tag_t   factor_wtag;
    cnt_t   factor_wuses;
    shift_t factor_shift;
    tag_t   factor_tag;
    cnt_t   factor_uses;
    logic   factor_full;
    logic   factor_empty;

    logic   issue_valid;
    acc_t   issue_part;
    acc_t   issue_add;
    shift_t issue_shift;
    tag_t   issue_tag;
    logic   pipe_valid;
    acc_t   pipe_sum;
    tag_t   pipe_tag;

    cnt_t   in_flight;
    logic   reducing;
    logic   accepting;

    // Scale waits until queued addends have entered the loop
    assign ready_o = accepting & ~addend_full & ~factor_full
                   & ~(scale_valid_i & ~addend_empty);

    sacc_tag_fifo #(
        .DEPTH (ADDEND_DEPTH),
        .WIDTH (ACC_W + TAG_W)
    ) u_addend_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (addend_push),
        .pop_i   (addend_pop),
        .data_i  ({addend_wdata, addend_wtag}),
        .data_o  ({addend_data, addend_tag}),
        .full_o  (addend_full),
        .empty_o (addend_empty)
    );

    sacc_tag_fifo #(
        .DEPTH (FACTOR_DEPTH),
        .WIDTH (SHIFT_W + TAG_W + CNT_W)
    ) u_factor_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (factor_push),
        .pop_i   (factor_pop),
        .data_i  ({scale_i, factor_wtag, factor_wuses}),
        .data_o  ({factor_shift, factor_tag, factor_uses}),
        .full_o  (factor_full),
        .empty_o (factor_empty)
    );

    sacc_scheduler u_scheduler (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .add_valid_i    (add_valid_i),
        .scale_valid_i  (scale_valid_i),
        .ready_i        (ready_o),
        .reducing_i     (reducing),
        .add_i          (add_i),
        .addend_data_i  (addend_data),
        .addend_tag_i   (addend_tag),
        .addend_empty_i (addend_empty),
        .factor_shift_i (factor_shift),
        .factor_tag_i   (factor_tag),
        .factor_uses_i  (factor_uses),
        .factor_empty_i (factor_empty),
        .pipe_valid_i   (pipe_valid),
        .pipe_sum_i     (pipe_sum),
        .pipe_tag_i     (pipe_tag),
        .addend_push_o  (addend_push),
        .addend_pop_o   (addend_pop),
        .addend_data_o  (addend_wdata),
        .addend_tag_o   (addend_wtag),
        .factor_push_o  (factor_push),
        .factor_pop_o   (factor_pop),
        .factor_tag_o   (factor_wtag),
        .factor_uses_o  (factor_wuses),
        .issue_valid_o  (issue_valid),
        .issue_part_o   (issue_part),
        .issue_add_o    (issue_add),
        .issue_shift_o  (issue_shift),
        .issue_tag_o    (issue_tag),
        .in_flight_o    (in_flight)
    );

    sacc_shift_add_pipe u_pipe (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .valid_i (issue_valid),
        .part_i  (issue_part),
        .add_i   (issue_add),
        .shift_i (issue_shift),
        .tag_i   (issue_tag),
        .valid_o (pipe_valid),
        .sum_o   (pipe_sum),
        .tag_o   (pipe_tag)
    );

    sacc_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .reduce_i       (reduce_i),
        .in_flight_i    (in_flight),
        .addend_empty_i (addend_empty),
        .factor_empty_i (factor_empty),
        .pipe_valid_i   (pipe_valid),
        .pipe_sum_i     (pipe_sum),
        .reducing_o     (reducing),
        .accepting_o    (accepting),
        .valid_o        (valid_o),
        .acc_o          (acc_o)
    );

endmodule

/* verilog/sacc_ctrl.sv */
// Phase control and result register
`timescale 1ns/1ps

module sacc_ctrl (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            clear_i,
    input  logic            reduce_i,
    input  sacc_pkg::cnt_t  in_flight_i,
    input  logic            addend_empty_i,
    input  logic            factor_empty_i,
    input  logic            pipe_valid_i,
    input  sacc_pkg::acc_t  pipe_sum_i,
    output logic            reducing_o,
    output logic            accepting_o,
    output logic            valid_o,
    output sacc_pkg::acc_t  acc_o
);
    import sacc_pkg::*;

    ctrl_state_e state_q;
    acc_t        acc_q;
    logic        nothing_queued;
    logic        last_sum;

    assign nothing_queued = (in_flight_i == '0) & addend_empty_i;

    // Single sum left and nothing waiting to merge
    assign last_sum = pipe_valid_i & (in_flight_i == cnt_t'(1))
                    & addend_empty_i & factor_empty_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            acc_q   <= '0;
        end else if (clear_i) begin
            state_q <= IDLE;
            acc_q   <= '0;
        end else begin
            unique case (state_q)
                IDLE, ACCUM: begin
                    if (reduce_i) begin
                        // Empty block finishes at once with zero
                        state_q <= nothing_queued ? DONE : REDUCE;
                    end else if (state_q == IDLE && !nothing_queued) begin
                        state_q <= ACCUM;
                    end
                end
                REDUCE: begin
                    if (last_sum) begin
                        state_q <= DONE;
                        acc_q   <= pipe_sum_i;
                    end
                end
                DONE: begin
                    state_q <= DONE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Scheduler stays in writeback mode once done
    assign reducing_o  = (state_q == REDUCE) | (state_q == DONE);
    assign accepting_o = (state_q == IDLE) | (state_q == ACCUM);
    assign valid_o     = (state_q == DONE);
    assign acc_o       = acc_q;

endmodule

/* verilog/sacc_shift_add_pipe.sv */
// Tagged shift-add pipeline
`timescale 1ns/1ps

module sacc_shift_add_pipe (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,
    input  sacc_pkg::acc_t    part_i,
    input  sacc_pkg::acc_t    add_i,
    input  sacc_pkg::shift_t  shift_i,
    input  sacc_pkg::tag_t    tag_i,
    output logic              valid_o,
    output sacc_pkg::acc_t    sum_o,
    output sacc_pkg::tag_t    tag_o
);
    import sacc_pkg::*;

    logic [NUM_STAGES-1:0] valid_q;
    tag_t                  tag_q [NUM_STAGES];
    acc_t                  shifted_q;
    acc_t                  add_q;
    acc_t                  sum_q [1:NUM_STAGES-1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[NUM_STAGES-2:0], valid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        // Stage one shifts, stage two adds
        shifted_q <= part_i >> shift_i;
        add_q     <= add_i;
        tag_q[0]  <= tag_i;
        sum_q[1]  <= shifted_q + add_q;
        for (int s = 1; s < NUM_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
        // Remaining stages only delay
        for (int s = 2; s < NUM_STAGES; s++) begin
            sum_q[s] <= sum_q[s-1];
        end
    end

    assign valid_o = valid_q[NUM_STAGES-1];
    assign sum_o   = sum_q[NUM_STAGES-1];
    assign tag_o   = tag_q[NUM_STAGES-1];

endmodule

/* verilog/sacc_scheduler.sv */
// Tag matching and operand scheduling
`timescale 1ns/1ps

module sacc_scheduler (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              clear_i,
    input  logic              add_valid_i,
    input  logic              scale_valid_i,
    input  logic              ready_i,
    input  logic              reducing_i,
    input  sacc_pkg::acc_t    add_i,
    input  sacc_pkg::acc_t    addend_data_i,
    input  sacc_pkg::tag_t    addend_tag_i,
    input  logic              addend_empty_i,
    input  sacc_pkg::shift_t  factor_shift_i,
    input  sacc_pkg::tag_t    factor_tag_i,
    input  sacc_pkg::cnt_t    factor_uses_i,
    input  logic              factor_empty_i,
    input  logic              pipe_valid_i,
    input  sacc_pkg::acc_t    pipe_sum_i,
    input  sacc_pkg::tag_t    pipe_tag_i,
    output logic              addend_push_o,
    output logic              addend_pop_o,
    output sacc_pkg::acc_t    addend_data_o,
    output sacc_pkg::tag_t    addend_tag_o,
    output logic              factor_push_o,
    output logic              factor_pop_o,
    output sacc_pkg::tag_t    factor_tag_o,
    output sacc_pkg::cnt_t    factor_uses_o,
    output logic              issue_valid_o,
    output sacc_pkg::acc_t    issue_part_o,
    output sacc_pkg::acc_t    issue_add_o,
    output sacc_pkg::shift_t  issue_shift_o,
    output sacc_pkg::tag_t    issue_tag_o,
    output sacc_pkg::cnt_t    in_flight_o
);
    import sacc_pkg::*;

    tag_t tag_q;
    cnt_t in_flight_q;
    cnt_t uses_q;
    tag_t next_tag;
    logic add_accept;
    logic scale_accept;
    logic factor_match;
    logic last_use;
    logic addend_hit;
    logic addend_hit_next;
    logic writeback;
    logic start_new;

    assign add_accept   = add_valid_i & ready_i;
    assign scale_accept = scale_valid_i & ready_i;
    assign next_tag     = pipe_tag_i + tag_t'(1);

    // Match decisions on the pipeline output
    assign factor_match    = pipe_valid_i & ~factor_empty_i & (factor_tag_i == pipe_tag_i);
    assign last_use        = factor_match & (uses_q == cnt_t'(factor_uses_i - 1'b1));
    assign addend_hit      = ~addend_empty_i & (addend_tag_i == pipe_tag_i);
    assign addend_hit_next = ~addend_empty_i & (addend_tag_i == next_tag);

    // Only fully scaled sums leave the loop during reduction
    assign writeback = pipe_valid_i & ~factor_match & ~addend_hit & reducing_i & factor_empty_i;

    // Free slot at the pipeline input
    assign start_new = ~pipe_valid_i & ~addend_empty_i & ~reducing_i
                     & (in_flight_q < cnt_t'(NUM_STAGES));

    always_comb begin
        issue_valid_o = 1'b0;
        issue_part_o  = pipe_sum_i;
        issue_add_o   = '0;
        issue_shift_o = '0;
        issue_tag_o   = pipe_tag_i;
        addend_pop_o  = 1'b0;
        if (pipe_valid_i) begin
            if (factor_match) begin
                issue_valid_o = 1'b1;
                issue_shift_o = factor_shift_i;
                issue_tag_o   = next_tag;
                if (addend_hit_next) begin
                    issue_add_o  = addend_data_i;
                    addend_pop_o = 1'b1;
                end
            end else if (addend_hit) begin
                issue_valid_o = 1'b1;
                issue_add_o   = addend_data_i;
                addend_pop_o  = 1'b1;
            end else if (!writeback) begin
                // Circulate plus zero
                issue_valid_o = 1'b1;
            end
        end else if (start_new) begin
            issue_valid_o = 1'b1;
            issue_part_o  = addend_data_i;
            issue_tag_o   = addend_tag_i;
            addend_pop_o  = 1'b1;
        end
    end

    assign addend_push_o = add_accept | writeback;
    assign addend_data_o = writeback ? pipe_sum_i : add_i;
    assign addend_tag_o  = writeback ? pipe_tag_i : tag_q;

    // A scale with nothing in flight has no sum to correct
    assign factor_uses_o = in_flight_q + cnt_t'(start_new);
    assign factor_push_o = scale_accept & (factor_uses_o != '0);
    assign factor_tag_o  = tag_q;
    assign factor_pop_o  = last_use;

    assign in_flight_o = in_flight_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_q       <= '0;
            in_flight_q <= '0;
            uses_q      <= '0;
        end else if (clear_i) begin
            tag_q       <= '0;
            in_flight_q <= '0;
            uses_q      <= '0;
        end else begin
            if (scale_accept) begin
                tag_q <= tag_q + tag_t'(1);
            end
            if (start_new) begin
                in_flight_q <= in_flight_q + cnt_t'(1);
            end else if (writeback) begin
                in_flight_q <= in_flight_q - cnt_t'(1);
            end
            if (factor_match) begin
                uses_q <= last_use ? '0 : uses_q + cnt_t'(1);
            end
        end
    end

    // Every pipeline output belongs to a counted sum, so the count cannot wrap
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pipe_valid_i |-> (in_flight_q != '0));

endmodule

/* verilog/sacc_tag_fifo.sv */
// Synchronous FIFO with flush
`timescale 1ns/1ps

module sacc_tag_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter int unsigned WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   fill_q;

    assign data_o  = mem_q[rd_ptr_q];
    assign full_o  = (fill_q == (PTR_W + 1)'(DEPTH));
    assign empty_o = (fill_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_i && !pop_i) begin
                fill_q <= fill_q + 1'b1;
            end else if (pop_i && !push_i) begin
                fill_q <= fill_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Writers upstream must respect full and empty
    assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i) push_i |-> !full_o);
    assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i) pop_i |-> !empty_o);

endmodule

/* verilog/sacc_pkg.sv */
// Scaled accumulator shared types
package sacc_pkg;

    // Datapath widths
    localparam int unsigned ACC_W        = 32;
    localparam int unsigned SHIFT_W      = 4;
    localparam int unsigned TAG_W        = 4;

    // Pipeline depth, also the in-flight limit
    localparam int unsigned NUM_STAGES   = 3;

    // Queue sizes
    localparam int unsigned ADDEND_DEPTH = 8;
    localparam int unsigned FACTOR_DEPTH = 4;

    // Holds 0 to NUM_STAGES
    localparam int unsigned CNT_W        = 2;

    typedef logic [ACC_W-1:0]   acc_t;
    typedef logic [SHIFT_W-1:0] shift_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [CNT_W-1:0]   cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        REDUCE,
        DONE
    } ctrl_state_e;

endpackage
